// ==== files.f ====
src/rv_pkg.sv
src/core_ctrl.sv
src/id_stage.sv
src/regfile.sv
src/ex_stage.sv
src/rv_core.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_rv_core -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// ==== sim/tb_rv_core.sv ====
// directed tests for the rv64i subset core; memories are word arrays and stores must be 8-byte aligned
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam logic [63:0] START_PC = 64'h0;
  // executed instructions over all tests, used to size the watchdog
  localparam int TOTAL_INSTR     = 51;
  localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 6 + 6 * 4 + 20 + 200;

  // standard rv32/rv64 major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic        clk;
  logic        rst;
  logic [63:0] imem_addr;
  logic [31:0] imem_data;
  dmem_req_t   dmem_req;
  logic [63:0] dmem_rdata;
  logic        halt;

  logic [31:0] imem [256];
  logic [63:0] dmem [256];
  logic [7:0]  pc_idx;
  int          errors;
  int          change_q [$];
  dmem_req_t   strobe_q [$];

  // combinational memory ports
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[10:3]];

  rv_core #(
    .RESET_PC (START_PC)
  ) i_rv_core (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype_word(input logic [2:0] f3, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] upper_value(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  // every doubleword differs, so stray writes show up
  function automatic logic [63:0] fill_word(input logic [63:0] addr);
    logic [7:0] idx;
    idx = addr[10:3];
    return {~idx, 24'h5a_c3_96, idx, 24'h0f_1e_2d};
  endfunction

  function automatic logic [63:0] dmem_at(input logic [63:0] addr);
    return dmem[addr[10:3]];
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // imem gets address-tagged nops, dmem the fill pattern
  task automatic clear_memories();
    for (int i = 0; i < 256; i++) begin
      imem[i] = itype_word(OPC_IMM, 5'd0, 3'd0, 5'd0, 12'(i));
      dmem[i] = fill_word(64'(i * 8));
    end
    pc_idx = 8'd0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[pc_idx] = word;
    pc_idx = pc_idx + 8'd1;
  endtask

  task automatic poke(input logic [63:0] addr, input logic [63:0] val);
    dmem[addr[10:3]] = val;
  endtask

  task automatic reset_core();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    check_eq(64'(halt), 64'd0, "halt after reset");
    check_eq(64'({dmem_req.ren, dmem_req.wen}), 64'd0, "dmem strobes after reset");
    check_eq(imem_addr, START_PC, "imem_addr after reset");
  endtask

  // samples mid-cycle, commits stores just after the edge that ends the strobe cycle
  task automatic run_to_halt();
    dmem_req_t   req;
    logic [63:0] last_addr;
    int          cyc;
    last_addr = imem_addr;
    cyc = 0;
    change_q.delete();
    strobe_q.delete();
    while (halt !== 1'b1) begin
      @(negedge clk);
      req = dmem_req;
      if (imem_addr !== last_addr) begin
        change_q.push_back(cyc);
        last_addr = imem_addr;
      end
      if (req.wen) begin
        strobe_q.push_back(req);
      end
      @(posedge clk);
      #1;
      if (req.wen) begin
        dmem[req.addr[10:3]] = (dmem[req.addr[10:3]] & ~req.wmask) | (req.wdata & req.wmask);
      end
      cyc++;
    end
  endtask

  task automatic alu_test();
    logic [11:0] a;
    logic [11:0] b;
    logic [11:0] c;
    a = 12'($urandom());
    b = 12'($urandom());
    c = 12'($urandom());
    clear_memories();
    emit(itype_word(OPC_IMM, 5'd1, 3'd0, 5'd0, a));
    emit(itype_word(OPC_IMM, 5'd2, 3'd0, 5'd0, b));
    emit(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    emit(rtype_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
    emit(itype_word(OPC_IMM, 5'd5, 3'd0, 5'd3, c));
    emit(itype_word(OPC_FENCE, 5'd0, 3'd0, 5'd0, 12'h0ff));
    emit(stype_word(3'd3, 5'd1, 5'd0, 12'h400));
    emit(stype_word(3'd3, 5'd3, 5'd0, 12'h408));
    emit(stype_word(3'd3, 5'd4, 5'd0, 12'h410));
    emit(stype_word(3'd3, 5'd5, 5'd0, 12'h418));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    check_eq(dmem_at(64'h400), sext12(a), "alu addi");
    check_eq(dmem_at(64'h408), sext12(a) + sext12(b), "alu add");
    check_eq(dmem_at(64'h410), sext12(a) - sext12(b), "alu sub");
    check_eq(dmem_at(64'h418), sext12(a) + sext12(b) + sext12(c), "alu addi chain");
  endtask

  task automatic upper_imm_test();
    logic [19:0] u1;
    logic [19:0] u2;
    u1 = 20'($urandom());
    u2 = 20'($urandom());
    clear_memories();
    // lui away from pc 0 so a stray pc add shows
    emit(utype_word(OPC_AUIPC, 5'd2, u2));
    emit(utype_word(OPC_LUI, 5'd1, u1));
    emit(stype_word(3'd3, 5'd1, 5'd0, 12'h400));
    emit(stype_word(3'd3, 5'd2, 5'd0, 12'h408));
    emit(utype_word(OPC_AUIPC, 5'd3, u1));
    emit(stype_word(3'd3, 5'd3, 5'd0, 12'h410));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    check_eq(dmem_at(64'h400), upper_value(u1), "lui value at pc 4");
    check_eq(dmem_at(64'h408), upper_value(u2), "auipc at pc 0");
    check_eq(dmem_at(64'h410), 64'd16 + upper_value(u1), "auipc at pc 16");
  endtask

  task automatic load_test();
    logic [63:0] r1;
    logic [63:0] r2;
    r1 = {$urandom(), $urandom()};
    r2 = {$urandom(), $urandom()};
    clear_memories();
    poke(64'h500, r1);
    poke(64'h508, r2);
    emit(itype_word(OPC_LOAD, 5'd1, 3'd3, 5'd0, 12'h500));
    emit(itype_word(OPC_IMM, 5'd6, 3'd0, 5'd0, 12'h500));
    // base register plus offset
    emit(itype_word(OPC_LOAD, 5'd2, 3'd3, 5'd6, 12'h008));
    emit(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    emit(stype_word(3'd3, 5'd3, 5'd0, 12'h510));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    check_eq(64'(strobe_q.size()), 64'd1, "load test store count");
    check_eq(dmem_at(64'h510), r1 + r2, "sum of loaded doublewords");
  endtask

  task automatic store_mask_test();
    logic [63:0] r;
    logic [63:0] mask [4];
    logic [63:0] addr;
    r = {$urandom(), $urandom()};
    mask[0] = 64'h0000_0000_0000_00ff;
    mask[1] = 64'h0000_0000_0000_ffff;
    mask[2] = 64'h0000_0000_ffff_ffff;
    mask[3] = 64'hffff_ffff_ffff_ffff;
    clear_memories();
    for (int k = 0; k < 4; k++) begin
      poke(64'h600 + 64'(k * 8), '1);
    end
    poke(64'h620, r);
    emit(itype_word(OPC_LOAD, 5'd1, 3'd3, 5'd0, 12'h620));
    emit(stype_word(3'd0, 5'd1, 5'd0, 12'h600));
    emit(stype_word(3'd1, 5'd1, 5'd0, 12'h608));
    emit(stype_word(3'd2, 5'd1, 5'd0, 12'h610));
    emit(stype_word(3'd3, 5'd1, 5'd0, 12'h618));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    check_eq(64'(strobe_q.size()), 64'd4, "store strobe count");
    for (int k = 0; k < 4; k++) begin
      addr = 64'h600 + 64'(k * 8);
      check_eq(strobe_q[k].addr, addr, $sformatf("store %0d address", k));
      check_eq(strobe_q[k].wmask, mask[k], $sformatf("store %0d wmask", k));
      check_eq(strobe_q[k].wdata, r, $sformatf("store %0d wdata", k));
      check_eq(dmem_at(addr), ~mask[k] | (r & mask[k]), $sformatf("store %0d memory", k));
    end
    check_eq(dmem_at(64'h628), fill_word(64'h628), "word after store targets");
  endtask

  task automatic control_flow_test();
    clear_memories();
    emit(itype_word(OPC_IMM, 5'd1, 3'd0, 5'd0, 12'd5));
    emit(itype_word(OPC_IMM, 5'd2, 3'd0, 5'd0, 12'd5));
    emit(itype_word(OPC_IMM, 5'd3, 3'd0, 5'd0, 12'd7));
    emit(itype_word(OPC_IMM, 5'd10, 3'd0, 5'd0, 12'h01a));
    emit(btype_word(3'd0, 5'd1, 5'd2, 13'd8));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h700));
    emit(btype_word(3'd0, 5'd1, 5'd3, 13'd8));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h708));
    emit(btype_word(3'd1, 5'd1, 5'd3, 13'd8));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h710));
    emit(btype_word(3'd1, 5'd1, 5'd2, 13'd8));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h718));
    emit(jtype_word(5'd5, 21'd8));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h720));
    emit(itype_word(OPC_IMM, 5'd6, 3'd0, 5'd0, 12'd72));
    // odd target, bit 0 must be dropped
    emit(itype_word(OPC_JALR, 5'd7, 3'd0, 5'd6, 12'd1));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h728));
    emit(stype_word(3'd3, 5'd10, 5'd0, 12'h730));
    emit(stype_word(3'd3, 5'd5, 5'd0, 12'h738));
    emit(stype_word(3'd3, 5'd7, 5'd0, 12'h740));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    // an odd pc would still fetch the same words, so the halted pc shows it
    check_eq(imem_addr, 64'd80, "ecall pc after odd jalr target");
    check_eq(64'(strobe_q.size()), 64'd4, "control flow store count");
    check_eq(dmem_at(64'h700), fill_word(64'h700), "taken beq skipped path");
    check_eq(dmem_at(64'h708), 64'h1a, "not-taken beq path");
    check_eq(dmem_at(64'h710), fill_word(64'h710), "taken bne skipped path");
    check_eq(dmem_at(64'h718), 64'h1a, "not-taken bne path");
    check_eq(dmem_at(64'h720), fill_word(64'h720), "jal skipped path");
    check_eq(dmem_at(64'h728), fill_word(64'h728), "jalr skipped path");
    check_eq(dmem_at(64'h730), fill_word(64'h730), "jalr skipped path");
    check_eq(dmem_at(64'h738), 64'd52, "jal link value");
    check_eq(dmem_at(64'h740), 64'd64, "jalr link value");
  endtask

  task automatic timing_halt_test();
    clear_memories();
    emit(itype_word(OPC_IMM, 5'd1, 3'd0, 5'd0, 12'd1));
    emit(itype_word(OPC_IMM, 5'd1, 3'd0, 5'd1, 12'd1));
    emit(itype_word(OPC_IMM, 5'd1, 3'd0, 5'd1, 12'd1));
    emit(stype_word(3'd3, 5'd1, 5'd0, 12'h780));
    emit(itype_word(OPC_SYSTEM, 5'd0, 3'd0, 5'd0, 12'h000));
    reset_core();
    run_to_halt();
    check_eq(dmem_at(64'h780), 64'd3, "timing program result");
    check_eq(64'(change_q.size()), 64'd4, "pc change count");
    // one idle cycle after reset, then six per instruction
    check_eq(64'(change_q[0]), 64'd7, "first pc change cycle");
    for (int k = 1; k < change_q.size(); k++) begin
      check_eq(64'(change_q[k] - change_q[k - 1]), 64'd6, "cycles between fetches");
    end
    for (int k = 0; k < 20; k++) begin
      @(negedge clk);
      check_eq(64'(halt), 64'd1, "halt held");
      check_eq(imem_addr, 64'd16, "imem_addr held on ecall");
      check_eq(64'({dmem_req.ren, dmem_req.wen}), 64'd0, "dmem idle after halt");
    end
  endtask

  initial begin
    rst = 1'b1;
    errors = 0;
    void'($urandom(58));
    clear_memories();
    alu_test();
    upper_imm_test();
    load_test();
    store_mask_test();
    control_flow_test();
    timing_halt_test();
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core did not halt in time",
             WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1);
  end

endmodule

// ==== src/core_ctrl.sv ====
// six-step instruction sequencer whose halt is sticky until reset and keeps pc on the ecall
`timescale 1ns/1ps

module core_ctrl #(
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] imem_data,
  input  logic        retire,
  input  logic [63:0] next_pc,
  input  logic        halt_req,
  output logic [7:0]  cycle_cnt,
  output logic [63:0] pc,
  output logic [31:0] inst,
  output logic        halt
);
  import rv_pkg::*;

  // instruction word returns in this step
  localparam logic [7:0] FETCH_CYCLE = 8'd2;

  logic stop;

  assign stop = halt || (retire && halt_req);

  // 0 after reset, then 1..LAST_CYCLE repeating
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else if (stop) begin
      cycle_cnt <= '0;
    end else if (cycle_cnt == LAST_CYCLE) begin
      cycle_cnt <= 8'd1;
    end else begin
      cycle_cnt <= cycle_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (retire && !halt_req) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (cycle_cnt == FETCH_CYCLE) begin
      inst <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (retire && halt_req) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== src/ex_stage.sv ====
// executes one decoded instruction per pass with memory at count 5 and write-back at count 6
`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic [7:0]        cycle_cnt,
  input  logic [63:0]       pc,
  input  rv_pkg::dec_t      dec,
  output rv_pkg::dmem_req_t dmem_req,
  input  logic [63:0]       dmem_rdata,
  output logic              rf_wen,
  output logic [4:0]        rf_waddr,
  output logic [63:0]       rf_wdata,
  output logic              retire,
  output logic [63:0]       next_pc,
  output logic              halt_req
);
  import rv_pkg::*;

  dec_t        dec_q;
  logic [63:0] load_q;
  logic [63:0] sum;
  logic [63:0] pc_inc;
  logic        is_load;
  logic        is_store;
  logic        mem_cycle;
  logic        taken;
  logic        writes_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '0;
    end else if (cycle_cnt == ID_CYCLE) begin
      dec_q <= dec;
    end
  end

  assign is_load   = (dec_q.opcode == OP_LOAD);
  assign is_store  = (dec_q.opcode == OP_STORE);
  assign mem_cycle = dec_q.valid && (cycle_cnt == ID_CYCLE + 8'd1);
  assign sum       = dec_q.op1 + dec_q.op2;
  assign pc_inc    = pc + 64'd4;

  // one-cycle data memory strobe
  always_comb begin
    dmem_req = '0;
    if (mem_cycle && (is_load || is_store)) begin
      dmem_req.ren   = is_load;
      dmem_req.wen   = is_store;
      dmem_req.addr  = sum;
      dmem_req.wdata = dec_q.store_data;
      dmem_req.wmask = dec_q.wmask;
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_req.ren) begin
      load_q <= dmem_rdata;
    end
  end

  // write-back value
  always_comb begin
    case (dec_q.opcode)
      OP_LOAD: rf_wdata = load_q;
      OP_JAL:  rf_wdata = dec_q.op1;
      OP_JALR: rf_wdata = dec_q.t1;
      OP_REG:  rf_wdata = dec_q.funct7[5] ? dec_q.op1 - dec_q.op2 : sum;
      default: rf_wdata = sum;
    endcase
  end

  always_comb begin
    taken = 1'b0;
    if (dec_q.opcode == OP_BRANCH) begin
      case (dec_q.funct3)
        FUNCT3_BEQ: taken = (dec_q.op1 == dec_q.op2);
        FUNCT3_BNE: taken = (dec_q.op1 != dec_q.op2);
        default:    taken = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (dec_q.opcode)
      OP_BRANCH: next_pc = taken ? dec_q.t1 : pc_inc;
      OP_JAL:    next_pc = dec_q.op2;
      OP_JALR:   next_pc = {sum[63:1], 1'b0};
      default:   next_pc = pc_inc;
    endcase
  end

  assign writes_rd = dec_q.opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                          OP_LOAD, OP_IMM, OP_REG};

  assign retire   = dec_q.valid && (cycle_cnt == LAST_CYCLE);
  assign rf_wen   = retire && writes_rd;
  assign rf_waddr = dec_q.rd;
  // ecall stops the core at retire
  assign halt_req = retire && (dec_q.opcode == OP_SYSTEM);

endmodule

// ==== src/id_stage.sv ====
// decode is active only at count ID_CYCLE and all outputs are zero in any other cycle
`timescale 1ns/1ps

module id_stage (
  input  logic          clk,
  input  logic          rst,
  input  logic [7:0]    cycle_cnt,
  input  logic [31:0]   inst,
  input  logic [63:0]   pc,
  input  logic [63:0]   rs1_data,
  input  logic [63:0]   rs2_data,
  output logic          rs1_ren,
  output logic          rs2_ren,
  output logic [4:0]    rs1,
  output logic [4:0]    rs2,
  output rv_pkg::dec_t  dec
);
  import rv_pkg::*;

  logic        id_active;
  opcode_e     opcode;
  itype_e      itype_d;
  itype_e      itype_q;
  logic [63:0] imm_d;
  logic [63:0] imm_q;
  logic [63:0] op1;
  logic [63:0] op2;
  logic [63:0] t1;
  logic [63:0] wmask;

  assign id_active = (cycle_cnt == ID_CYCLE);
  assign opcode    = opcode_e'(inst[6:2]);

  // instruction format from the major opcode
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC:                             itype_d = IT_U;
      OP_JAL:                                       itype_d = IT_J;
      OP_JALR, OP_LOAD, OP_IMM, OP_FENCE, OP_SYSTEM: itype_d = IT_I;
      OP_BRANCH:                                    itype_d = IT_B;
      OP_STORE:                                     itype_d = IT_S;
      OP_REG:                                       itype_d = IT_R;
      default:                                      itype_d = IT_NONE;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (itype_d)
      IT_I:    imm_d = {{52{inst[31]}}, inst[31:20]};
      IT_S:    imm_d = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      IT_B:    imm_d = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      IT_U:    imm_d = {{32{inst[31]}}, inst[31:12], 12'b0};
      IT_J:    imm_d = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm_d = '0;
    endcase
  end

  // inst is stable from count 3, so format and immediate settle a cycle early
  always_ff @(posedge clk) begin
    if (rst) begin
      itype_q <= IT_NONE;
    end else if (cycle_cnt == ID_CYCLE - 8'd1) begin
      itype_q <= itype_d;
    end
  end

  always_ff @(posedge clk) begin
    if (cycle_cnt == ID_CYCLE - 8'd1) begin
      imm_q <= imm_d;
    end
  end

  // register file reads
  assign rs1     = id_active ? inst[19:15] : 5'd0;
  assign rs2     = id_active ? inst[24:20] : 5'd0;
  assign rs1_ren = id_active && (itype_q inside {IT_R, IT_I, IT_S, IT_B});
  assign rs2_ren = id_active && (itype_q inside {IT_R, IT_S, IT_B});

  // operands
  always_comb begin
    case (itype_q)
      IT_R, IT_B: begin
        op1 = rs1_data;
        op2 = rs2_data;
      end
      IT_I, IT_S: begin
        op1 = rs1_data;
        op2 = imm_q;
      end
      IT_J: begin
        op1 = pc + 64'd4;
        op2 = pc + imm_q;
      end
      IT_U: begin
        op1 = (opcode == OP_AUIPC) ? pc : 64'd0;
        op2 = imm_q;
      end
      default: begin
        op1 = '0;
        op2 = '0;
      end
    endcase
  end

  // link value for jalr, target for branches
  always_comb begin
    case (opcode)
      OP_JALR:   t1 = pc + 64'd4;
      OP_BRANCH: t1 = pc + imm_q;
      default:   t1 = '0;
    endcase
  end

  always_comb begin
    wmask = '0;
    if (itype_q == IT_S) begin
      case (inst[14:12])
        FUNCT3_SB: wmask = 64'h0000_0000_0000_00ff;
        FUNCT3_SH: wmask = 64'h0000_0000_0000_ffff;
        FUNCT3_SW: wmask = 64'h0000_0000_ffff_ffff;
        FUNCT3_SD: wmask = 64'hffff_ffff_ffff_ffff;
        default:   wmask = '0;
      endcase
    end
  end

  always_comb begin
    dec = '0;
    if (id_active) begin
      dec.valid      = 1'b1;
      dec.opcode     = opcode;
      dec.itype      = itype_q;
      dec.funct3     = inst[14:12];
      dec.funct7     = inst[31:25];
      dec.rd         = inst[11:7];
      dec.op1        = op1;
      dec.op2        = op2;
      dec.t1         = t1;
      dec.store_data = rs2_data;
      dec.wmask      = wmask;
    end
  end

endmodule

// ==== src/regfile.sv ====
// 32 x 64-bit registers with x0 tied to zero and disabled reads returning zero
`timescale 1ns/1ps

module regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        rs1_ren,
  input  logic        rs2_ren,
  output logic [63:0] rs1_data,
  output logic [63:0] rs2_data,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [63:0] wdata
);

  logic [63:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 never holds a value
  assign rs1_data = (rs1_ren && (rs1 != 5'd0)) ? regs[rs1] : 64'd0;
  assign rs2_data = (rs2_ren && (rs2 != 5'd0)) ? regs[rs2] : 64'd0;

endmodule

// ==== src/rv_core.sv ====
// top of the rv64i subset core with combinational instruction and data memory ports
`timescale 1ns/1ps

module rv_core #(
  parameter logic [63:0] RESET_PC = 64'h0
) (
  input  logic              clk,
  input  logic              rst,
  output logic [63:0]       imem_addr,
  input  logic [31:0]       imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  logic [63:0]       dmem_rdata,
  output logic              halt
);
  import rv_pkg::*;

  logic [7:0]  cycle_cnt;
  logic [63:0] pc;
  logic [31:0] inst;
  logic        rs1_ren;
  logic        rs2_ren;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  dec_t        dec;
  logic        rf_wen;
  logic [4:0]  rf_waddr;
  logic [63:0] rf_wdata;
  logic        retire;
  logic [63:0] next_pc;
  logic        halt_req;

  // pc is held for the whole instruction
  assign imem_addr = pc;

  core_ctrl #(
    .RESET_PC (RESET_PC)
  ) i_core_ctrl (
    .clk       (clk),
    .rst       (rst),
    .imem_data (imem_data),
    .retire    (retire),
    .next_pc   (next_pc),
    .halt_req  (halt_req),
    .cycle_cnt (cycle_cnt),
    .pc        (pc),
    .inst      (inst),
    .halt      (halt)
  );

  id_stage i_id_stage (
    .clk       (clk),
    .rst       (rst),
    .cycle_cnt (cycle_cnt),
    .inst      (inst),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_ren   (rs1_ren),
    .rs2_ren   (rs2_ren),
    .rs1       (rs1),
    .rs2       (rs2),
    .dec       (dec)
  );

  regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_ren  (rs1_ren),
    .rs2_ren  (rs2_ren),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  ex_stage i_ex_stage (
    .clk        (clk),
    .rst        (rst),
    .cycle_cnt  (cycle_cnt),
    .pc         (pc),
    .dec        (dec),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .retire     (retire),
    .next_pc    (next_pc),
    .halt_req   (halt_req)
  );

endmodule

// ==== src/rv_pkg.sv ====
// shared types for the multicycle rv64i subset core, which knows only the opcodes in opcode_e
package rv_pkg;

  // instruction cycle steps
  localparam logic [7:0] ID_CYCLE   = 8'd4;
  localparam logic [7:0] LAST_CYCLE = 8'd6;

  // store widths
  localparam logic [2:0] FUNCT3_SB  = 3'b000;
  localparam logic [2:0] FUNCT3_SH  = 3'b001;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;
  localparam logic [2:0] FUNCT3_SD  = 3'b011;

  // branch conditions
  localparam logic [2:0] FUNCT3_BEQ = 3'b000;
  localparam logic [2:0] FUNCT3_BNE = 3'b001;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_FENCE  = 5'b00011,
    OP_IMM    = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_REG    = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYSTEM = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    IT_R    = 3'd0,
    IT_I    = 3'd1,
    IT_S    = 3'd2,
    IT_B    = 3'd3,
    IT_U    = 3'd4,
    IT_J    = 3'd5,
    IT_NONE = 3'd6
  } itype_e;

  // decoded instruction, valid only at ID_CYCLE
  typedef struct packed {
    logic        valid;
    opcode_e     opcode;
    itype_e      itype;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic [63:0] op1;
    logic [63:0] op2;
    logic [63:0] t1;
    logic [63:0] store_data;
    logic [63:0] wmask;
  } dec_t;

  // data memory request, bit mask not shifted by address
  typedef struct packed {
    logic        ren;
    logic        wen;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [63:0] wmask;
  } dmem_req_t;

endpackage
